// File: dv/tbAluCore.sv
`timescale 1ns/1ps

module tbAluCore;

    localparam int NumInstr = 400;
    localparam int DrainLimit = 20;

    // R-type functions, I-type opcodes and reserved opcodes to draw from
    localparam logic [5:0] rFuncts [8] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h00, 6'h2a, 6'h2b};
    localparam logic [5:0] iOps [5] = '{6'h08, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
    localparam logic [5:0] otherOps [8] = '{6'h23, 6'h2b, 6'h04, 6'h05, 6'h02, 6'h03, 6'h10, 6'h1c};

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        wbRi;
    logic        wbOv;

    logic [31:0]    lfsr;
    logic [31:0]    model [32];
    corePkg::wbRecS expQ [$];
    int             dueQ [$];
    corePkg::wbRecS expRec;
    int             dueCyc;
    int             cyc;
    int             errors;
    int             timeouts;
    int             waitCnt;
    logic [31:0]    gap;

    aluCore u_aluCore (
        .clk       (clk),
        .arstN     (arstN),
        .instrValid(instrValid),
        .instr     (instr),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .wbRi      (wbRi),
        .wbOv      (wbOv)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic fb;
        randBits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            randBits = {randBits[30:0], fb};
        end
    endfunction

    // mostly r1..r4 so dependencies are frequent
    function automatic logic [4:0] regPick();
        logic [31:0] r;
        r = randBits(3);
        if (r == 0) begin
            r = randBits(5);
        end else begin
            r = randBits(2) + 1;
        end
        regPick = r[4:0];
    endfunction

    function automatic logic [31:0] genInstr();
        logic [31:0] k;
        logic [31:0] imm;
        logic [31:0] raw;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [4:0]  sh;
        k = randBits(4);
        imm = randBits(16);
        raw = randBits(29);
        rs = regPick();
        rt = regPick();
        rd = regPick();
        if (k < 8) begin
            fn = rFuncts[k[2:0]];
            sh = (fn == 6'h00) ? imm[4:0] : 5'h00;
            genInstr = {6'h00, rs, rt, rd, sh, fn};
        end else if (k < 13) begin
            genInstr = {iOps[k[2:0]], rs, rt, imm[15:0]};
        end else if (k == 13) begin
            genInstr = {otherOps[raw[28:26]], raw[25:0]};
        end else if (k == 14) begin
            // mult
            genInstr = {6'h00, rs, rt, 10'h000, 6'h18};
        end else begin
            genInstr = 32'h0;
        end
    endfunction

    // expected record with its write applied to the model at issue time
    function automatic corePkg::wbRecS predict(input logic [31:0] ins);
        corePkg::wbRecS r;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [32:0]    wide;
        r = '0;
        wide = '0;
        a = model[ins[25:21]];
        b = model[ins[20:16]];
        if (ins == 32'h0) begin
            r.addr = 5'h00;
        end else if (ins[31:26] == 6'h00) begin
            r.addr = ins[15:11];
            case (ins[5:0])
                6'h20:   wide = {a[31], a} + {b[31], b};
                6'h22:   wide = {a[31], a} - {b[31], b};
                6'h24:   wide = {1'b0, a & b};
                6'h25:   wide = {1'b0, a | b};
                6'h26:   wide = {1'b0, a ^ b};
                6'h00:   wide = {1'b0, b << ins[10:6]};
                6'h2a:   wide = {32'h0, $signed(a) < $signed(b)};
                6'h2b:   wide = {32'h0, a < b};
                default: r.ri = 1'b1;
            endcase
            r.ov = (ins[5:0] == 6'h20 || ins[5:0] == 6'h22) && (wide[32] != wide[31]);
        end else begin
            r.addr = ins[20:16];
            case (ins[31:26])
                6'h08:   wide = {a[31], a} + {{17{ins[15]}}, ins[15:0]};
                6'h0c:   wide = {17'h0, a[15:0] & ins[15:0]};
                6'h0d:   wide = {1'b0, a[31:16], a[15:0] | ins[15:0]};
                6'h0e:   wide = {1'b0, a[31:16], a[15:0] ^ ins[15:0]};
                6'h0f:   wide = {1'b0, ins[15:0], 16'h0000};
                default: r.ri = 1'b1;
            endcase
            r.ov = (ins[31:26] == 6'h08) && (wide[32] != wide[31]);
        end
        r.data = wide[31:0];
        if (!r.ri && !r.ov && r.addr != 5'h00) begin
            model[r.addr] = r.data;
        end
        predict = r;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic issueInstr(input logic [31:0] ins);
        @(negedge clk);
        instr = ins;
        instrValid = 1'b1;
        expQ.push_back(predict(ins));
        // record due two rising edges later
        dueQ.push_back(cyc + 2);
    endtask

    always @(negedge clk) begin
        if (arstN && wbValid) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("Write-back pulse with no instruction outstanding at %0t", $time);
            end else begin
                expRec = expQ.pop_front();
                dueCyc = dueQ.pop_front();
                checkVal("wbCycle", cyc, dueCyc);
                checkVal("wbRi", 32'(wbRi), 32'(expRec.ri));
                checkVal("wbOv", 32'(wbOv), 32'(expRec.ov));
                if (!expRec.ri) begin
                    checkVal("wbAddr", 32'(wbAddr), 32'(expRec.addr));
                    checkVal("wbData", wbData, expRec.data);
                end
            end
        end
    end

    initial begin
        lfsr = 32'hf9cfe01e;
        errors = 0;
        timeouts = 0;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'h0;
        end
        repeat (4) @(negedge clk);
        arstN = 1'b1;

        // idle outputs before the first strobe
        repeat (3) begin
            @(negedge clk);
            checkVal("wbValid", 32'(wbValid), 32'h0);
            checkVal("wbRi", 32'(wbRi), 32'h0);
            checkVal("wbOv", 32'(wbOv), 32'h0);
        end

        // back-to-back overflows and a read of the untouched r2
        issueInstr(32'h3c017fff);
        issueInstr(32'h3421ffff);
        issueInstr(32'h20220001);
        issueInstr(32'h00211820);
        issueInstr(32'h3c048000);
        issueInstr(32'h00812822);
        issueInstr(32'h00403020);

        // write aimed at r0, then reads of r0 one, two and three slots on
        issueInstr(32'h34200005);
        issueInstr(32'h00003820);
        issueInstr(32'h00003820);
        issueInstr(32'h00003820);

        for (int n = 0; n < NumInstr; n++) begin
            gap = randBits(3);
            if (gap == 0) begin
                @(negedge clk);
                instrValid = 1'b0;
                instr = randBits(32);
            end else begin
                issueInstr(genInstr());
            end
        end

        @(negedge clk);
        instrValid = 1'b0;
        instr = 32'h0;
        waitCnt = 0;
        while (expQ.size() != 0 && waitCnt < DrainLimit) begin
            @(negedge clk);
            waitCnt++;
        end
        if (expQ.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d write-back records never arrived", expQ.size());
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tbAluCore -o simv &&
out=$(./obj_dir/simv) &&
echo "$out" &&
echo "$out" | grep -q "SIMULATION PASSED" || exit 1

// File: source/aluCore.sv
`timescale 1ns/1ps
`include "coreCfg.svh"

module aluCore (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     instrValid,
    input  logic [31:0]              instr,
    output logic                     wbValid,
    output logic [`CORE_RADDR_W-1:0] wbAddr,
    output logic [`CORE_DATA_W-1:0]  wbData,
    output logic                     wbRi,
    output logic                     wbOv
);

    corePkg::issueS           issueD;
    corePkg::issueS           issueQ;
    corePkg::wbRecS           wbD;
    corePkg::wbRecS           wbQ;
    logic                     issueValid;
    logic [`CORE_RADDR_W-1:0] rdAddrA;
    logic [`CORE_RADDR_W-1:0] rdAddrB;
    logic [`CORE_DATA_W-1:0]  rdDataA;
    logic [`CORE_DATA_W-1:0]  rdDataB;

    operandFetch u_operandFetch (
        .instr       (instr),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .fwdNear     (wbD),
        .fwdFar      (wbQ),
        .fwdNearValid(issueValid),
        .fwdFarValid (wbValid),
        .issue       (issueD)
    );

    regFile u_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wbValid & ~wbQ.ri & ~wbQ.ov),
        .wrAddr (wbQ.addr),
        .wrData (wbQ.data)
    );

    pipeStage #(.payloadT(corePkg::issueS)) u_stageA (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (instrValid),
        .inData  (issueD),
        .outValid(issueValid),
        .outData (issueQ)
    );

    aluUnit u_aluUnit (
        .issue(issueQ),
        .wb   (wbD)
    );

    pipeStage #(.payloadT(corePkg::wbRecS)) u_stageB (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (issueValid),
        .inData  (wbD),
        .outValid(wbValid),
        .outData (wbQ)
    );

    assign wbAddr = wbQ.addr;
    assign wbData = wbQ.data;
    assign wbRi   = wbQ.ri;
    assign wbOv   = wbQ.ov;

endmodule

// File: source/aluUnit.sv
`timescale 1ns/1ps
`include "coreCfg.svh"

module aluUnit (
    input  corePkg::issueS issue,
    output corePkg::wbRecS wb
);

    localparam int W = `CORE_DATA_W;

    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] sum;
    logic [W-1:0] diff;
    logic [W-1:0] result;
    logic         addOv;
    logic         subOv;

    assign a    = issue.opA;
    assign b    = issue.opB;
    assign sum  = a + b;
    assign diff = a - b;

    // sign of result disagrees with the operands
    assign addOv = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
    assign subOv = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

    always_comb begin
        result = '0;
        case (issue.ctrl.aluOp)
            corePkg::aluAdd:  result = sum;
            corePkg::aluSub:  result = diff;
            corePkg::aluAnd:  result = a & b;
            corePkg::aluOr:   result = a | b;
            corePkg::aluXor:  result = a ^ b;
            corePkg::aluSll:  result = b << issue.shamt;
            corePkg::aluSlt:  result[0] = $signed(a) < $signed(b);
            corePkg::aluSltu: result[0] = a < b;
            default:          result = sum;
        endcase
    end

    assign wb.addr = issue.ctrl.destAddr;
    assign wb.data = result;
    assign wb.ri   = issue.ctrl.riFault;
    assign wb.ov   = issue.ctrl.ovCheck &&
                     ((issue.ctrl.aluOp == corePkg::aluSub) ? subOv : addOv);

endmodule

// File: source/controller.sv
`timescale 1ns/1ps
`include "coreCfg.svh"

module controller (
    input  logic [31:0]         instr,
    output corePkg::decodeCtrlS ctrl
);

    logic [5:0]               opcode;
    logic [5:0]               funct;
    logic [`CORE_RADDR_W-1:0] rt;
    logic [`CORE_RADDR_W-1:0] rd;
    logic rType;
    logic nop;
    logic isAdd, isSub, isAnd, isOr, isXor, isSll, isSlt, isSltu;
    logic isAddi, isAndi, isOri, isXori, isLui;
    logic calcR;
    logic calcI;
    logic foreign;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    assign rType  = (opcode == `OP_SPECIAL);
    assign nop    = (instr == '0);
    assign isAdd  = rType && (funct == `FN_ADD);
    assign isSub  = rType && (funct == `FN_SUB);
    assign isAnd  = rType && (funct == `FN_AND);
    assign isOr   = rType && (funct == `FN_OR);
    assign isXor  = rType && (funct == `FN_XOR);
    assign isSll  = rType && (funct == `FN_SLL);
    assign isSlt  = rType && (funct == `FN_SLT);
    assign isSltu = rType && (funct == `FN_SLTU);
    assign isAddi = (opcode == `OP_ADDI);
    assign isAndi = (opcode == `OP_ANDI);
    assign isOri  = (opcode == `OP_ORI);
    assign isXori = (opcode == `OP_XORI);
    assign isLui  = (opcode == `OP_LUI);

    assign calcR = isAdd | isSub | isAnd | isOr | isXor | isSll | isSlt | isSltu;
    assign calcI = isAddi | isAndi | isOri | isXori | isLui;

    // memory, control flow, cop0 and mdu classes
    assign foreign = (opcode[5:3] == `OP_LOAD_GRP)
                   | (opcode[5:3] == `OP_STORE_GRP)
                   | (opcode[5:2] == `OP_BRANCH_GRP)
                   | (opcode == `OP_REGIMM)
                   | (opcode[5:1] == `OP_JUMP_GRP)
                   | (opcode == `OP_COP0)
                   | (opcode == `OP_SPECIAL2);

    always_comb begin
        if (isSub) begin
            ctrl.aluOp = corePkg::aluSub;
        end else if (isAnd || isAndi) begin
            ctrl.aluOp = corePkg::aluAnd;
        end else if (isOr || isOri) begin
            ctrl.aluOp = corePkg::aluOr;
        end else if (isXor || isXori) begin
            ctrl.aluOp = corePkg::aluXor;
        end else if (isSll) begin
            ctrl.aluOp = corePkg::aluSll;
        end else if (isSlt) begin
            ctrl.aluOp = corePkg::aluSlt;
        end else if (isSltu) begin
            ctrl.aluOp = corePkg::aluSltu;
        end else begin
            ctrl.aluOp = corePkg::aluAdd;
        end

        if (isAddi) begin
            ctrl.extMode = corePkg::extSign;
        end else if (isLui) begin
            ctrl.extMode = corePkg::extUpper;
        end else begin
            ctrl.extMode = corePkg::extZero;
        end

        ctrl.aluSrcImm = calcI;
        ctrl.ovCheck   = isAdd | isSub | isAddi;
        // nop decodes as sll to r0 and never writes
        ctrl.regWrite  = (calcR | calcI) & ~nop;
        ctrl.riFault   = foreign | ~(nop | calcR | calcI);
        ctrl.destAddr  = ctrl.regWrite ? (rType ? rd : rt) : '0;

        assert (!(ctrl.riFault && ctrl.regWrite));
    end

endmodule

// File: source/coreCfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_DATA_W 32
`define CORE_RADDR_W 5

// executed opcodes
`define OP_SPECIAL 6'b000000
`define OP_ADDI 6'b001000
`define OP_ANDI 6'b001100
`define OP_ORI 6'b001101
`define OP_XORI 6'b001110
`define OP_LUI 6'b001111

// recognised only, so they decode as reserved
`define OP_REGIMM 6'b000001
`define OP_COP0 6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_JUMP_GRP 5'b00001
`define OP_BRANCH_GRP 4'b0001
`define OP_LOAD_GRP 3'b100
`define OP_STORE_GRP 3'b101

`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_XOR 6'b100110
`define FN_SLL 6'b000000
`define FN_SLT 6'b101010
`define FN_SLTU 6'b101011

`endif

// File: source/corePkg.sv
`include "coreCfg.svh"

package corePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSlt,
        aluSltu
    } aluOpE;

    // immediate extension
    typedef enum logic [1:0] {
        extZero,
        extSign,
        extUpper
    } extModeE;

    typedef struct packed {
        aluOpE                    aluOp;
        extModeE                  extMode;
        logic                     aluSrcImm;
        logic                     regWrite;
        logic                     ovCheck;
        logic                     riFault;
        logic [`CORE_RADDR_W-1:0] destAddr;
    } decodeCtrlS;

    // operand fetch to alu
    typedef struct packed {
        decodeCtrlS              ctrl;
        logic [`CORE_DATA_W-1:0] opA;
        logic [`CORE_DATA_W-1:0] opB;
        logic [4:0]              shamt;
    } issueS;

    typedef struct packed {
        logic [`CORE_RADDR_W-1:0] addr;
        logic [`CORE_DATA_W-1:0]  data;
        logic                     ri;
        logic                     ov;
    } wbRecS;

endpackage

// File: source/operandFetch.sv
`timescale 1ns/1ps
`include "coreCfg.svh"

module operandFetch (
    input  logic [31:0]                instr,
    output logic [`CORE_RADDR_W-1:0]   rdAddrA,
    output logic [`CORE_RADDR_W-1:0]   rdAddrB,
    input  logic [`CORE_DATA_W-1:0]    rdDataA,
    input  logic [`CORE_DATA_W-1:0]    rdDataB,
    input  corePkg::wbRecS             fwdNear,
    input  corePkg::wbRecS             fwdFar,
    input  logic                       fwdNearValid,
    input  logic                       fwdFarValid,
    output corePkg::issueS             issue
);

    corePkg::decodeCtrlS     ctrl;
    logic [`CORE_DATA_W-1:0] rsVal;
    logic [`CORE_DATA_W-1:0] rtVal;
    logic [`CORE_DATA_W-1:0] immExt;

    function automatic logic fwdHit(
        input corePkg::wbRecS             rec,
        input logic                       recValid,
        input logic [`CORE_RADDR_W-1:0]   addr
    );
        fwdHit = recValid && !rec.ri && !rec.ov && (rec.addr != '0) && (rec.addr == addr);
    endfunction

    controller u_controller (
        .instr(instr),
        .ctrl (ctrl)
    );

    assign rdAddrA = instr[25:21];
    assign rdAddrB = instr[20:16];

    // the near record is younger than the far one and wins
    assign rsVal = fwdHit(fwdNear, fwdNearValid, rdAddrA) ? fwdNear.data :
                   fwdHit(fwdFar, fwdFarValid, rdAddrA)   ? fwdFar.data  :
                   rdDataA;
    assign rtVal = fwdHit(fwdNear, fwdNearValid, rdAddrB) ? fwdNear.data :
                   fwdHit(fwdFar, fwdFarValid, rdAddrB)   ? fwdFar.data  :
                   rdDataB;

    always_comb begin
        case (ctrl.extMode)
            corePkg::extSign:  immExt = {{16{instr[15]}}, instr[15:0]};
            corePkg::extUpper: immExt = {instr[15:0], 16'h0000};
            default:           immExt = {16'h0000, instr[15:0]};
        endcase
    end

    assign issue.ctrl  = ctrl;
    // lui adds its immediate to zero and ignores rs
    assign issue.opA   = (ctrl.extMode == corePkg::extUpper) ? '0 : rsVal;
    assign issue.opB   = ctrl.aluSrcImm ? immExt : rtVal;
    assign issue.shamt = instr[10:6];

endmodule

// File: source/pipeStage.sv
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else begin
            outValid <= inValid;
            outData  <= inData;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid));

endmodule

// File: source/regFile.sv
`timescale 1ns/1ps
`include "coreCfg.svh"

module regFile (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [`CORE_RADDR_W-1:0] rdAddrA,
    input  logic [`CORE_RADDR_W-1:0] rdAddrB,
    output logic [`CORE_DATA_W-1:0]  rdDataA,
    output logic [`CORE_DATA_W-1:0]  rdDataB,
    input  logic                     wrEn,
    input  logic [`CORE_RADDR_W-1:0] wrAddr,
    input  logic [`CORE_DATA_W-1:0]  wrData
);

    localparam int NumRegs = 2 ** `CORE_RADDR_W;

    // r0 has no storage
    logic [`CORE_DATA_W-1:0] regs [1:NumRegs-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // reads show the stored value until the write edge
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    property writeKnown;
        @(posedge clk) disable iff (!arstN) wrEn |-> !$isunknown({wrAddr, wrData});
    endproperty

    assert property (writeKnown);

endmodule

// File: tb.f
+incdir+source
source/corePkg.sv
source/controller.sv
source/regFile.sv
source/operandFetch.sv
source/pipeStage.sv
source/aluUnit.sv
source/aluCore.sv
dv/tbAluCore.sv
